// ==== bench/axi_read_slave_model.sv ====
//////////////////////////////
// Memory slave, random AR and R gaps from the bench
// Word data is byte address xor 32'h5a5a0000
//////////////////////////////

`include "rd_master_settings.svh"

module axi_read_slave_model (
  input  logic                      aclk,
  input  logic                      areset,
  input  logic                      ready_roll,
  input  logic                      valid_roll,
  input  logic                      arvalid,
  input  logic [`RD_ADDR_WIDTH-1:0] araddr,
  input  logic [7:0]                arlen,
  output logic                      arready,
  input  logic                      rready,
  output logic                      rvalid,
  output logic [`RD_DATA_WIDTH-1:0] rdata,
  output logic                      rlast
);

  // Accepted bursts, indexes wrap, far fewer than 256 in flight
  logic [`RD_ADDR_WIDTH-1:0] addr_mem [256];
  logic [7:0]                len_mem [256];
  logic [7:0]                wr_idx;
  logic [7:0]                rd_idx;
  logic [7:0]                beat;

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rlast   = 1'b0;
    rdata   = '0;
  end

  // Handshakes seen at the rising edge
  always @(posedge aclk) begin
    if (areset !== 1'b0) begin
      wr_idx <= '0;
      rd_idx <= '0;
      beat   <= '0;
    end else begin
      if (arvalid && arready) begin
        addr_mem[wr_idx] <= araddr;
        len_mem[wr_idx]  <= arlen;
        wr_idx           <= wr_idx + 1'b1;
      end
      // Last beat retires the burst
      if (rvalid && rready) begin
        if (rlast) begin
          rd_idx <= rd_idx + 1'b1;
          beat   <= '0;
        end else begin
          beat <= beat + 1'b1;
        end
      end
    end
  end

  // Outputs change on the falling edge only
  always @(negedge aclk) begin
    if (areset !== 1'b0) begin
      arready = 1'b0;
      rvalid  = 1'b0;
      rlast   = 1'b0;
    end else begin
      arready = ready_roll;
      rvalid  = valid_roll && (wr_idx != rd_idx);
      rdata   = (addr_mem[rd_idx] + 4 * beat) ^ 32'h5a5a0000;
      rlast   = (beat == len_mem[rd_idx]);
    end
  end

endmodule

// ==== bench/rd_master_tb.sv ====
//////////////////////////////
// Random requests against a word-level model
// Next start only after done and a drained stream
//////////////////////////////

`include "rd_master_settings.svh"

module rd_master_tb;

  localparam int num_requests = 20;
  localparam int beats_per_burst = `RD_BURST_BEATS;
  localparam int word_bytes = `RD_DATA_WIDTH / 8;
  localparam int burst_bytes = beats_per_burst * word_bytes;
  localparam logic [31:0] data_pattern = 32'h5a5a0000;

  logic aclk;
  logic areset;
  logic ctrl_start;
  logic ctrl_done;
  logic [`RD_ADDR_WIDTH-1:0] ctrl_addr_offset;
  logic [`RD_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes;
  logic arvalid, arready, rvalid, rready, rlast;
  logic tvalid, tready, tlast;
  logic [`RD_ADDR_WIDTH-1:0] araddr;
  logic [7:0] arlen;
  logic [`RD_DATA_WIDTH-1:0] rdata, tdata;
  // Slave gap controls drawn from the one shared generator
  logic ready_roll, valid_roll;

  logic [31:0] rng_state;
  logic [31:0] req_addr [num_requests];
  int          req_size [num_requests];
  // Model queues filled at each start and emptied by the monitor
  logic [31:0] exp_data [$];
  logic        exp_last [$];
  logic [31:0] exp_araddr [$];
  logic [7:0]  exp_arlen [$];
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int cycle_limit = 0;
  int done_count = 0;
  int beats = 0;
  int exp_beats = 0;
  int outstanding = 0;
  int req_idx = 0;
  logic started = 1'b0;
  logic held = 1'b0;
  logic [31:0] held_data;
  logic held_last;

  rd_master_top uut (
    .aclk (aclk), .areset (areset), .ctrl_start (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes), .ctrl_done (ctrl_done),
    .m_axi_arvalid (arvalid), .m_axi_arready (arready),
    .m_axi_araddr (araddr), .m_axi_arlen (arlen),
    .m_axi_rvalid (rvalid), .m_axi_rready (rready),
    .m_axi_rdata (rdata), .m_axi_rlast (rlast),
    .m_axis_tvalid (tvalid), .m_axis_tready (tready),
    .m_axis_tdata (tdata), .m_axis_tlast (tlast)
  );

  axi_read_slave_model slave (
    .aclk (aclk), .areset (areset), .ready_roll (ready_roll), .valid_roll (valid_roll),
    .arvalid (arvalid), .araddr (araddr), .arlen (arlen), .arready (arready),
    .rready (rready), .rvalid (rvalid), .rdata (rdata), .rlast (rlast)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("At %0t: %s", $time, what);
  endtask

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  // Fresh back-pressure and slave gaps on each falling edge
  always @(negedge aclk) begin
    logic [31:0] r;
    if (areset === 1'b0) begin
      r = next_random();
      tready = r[0];
      ready_roll <= r[3:2] != 2'b00;
      valid_roll <= r[5:4] != 2'b00;
    end
  end

  //////////////////////////////
  // Stimulus and model
  //////////////////////////////

  initial begin
    int words;
    int bursts;
    logic [31:0] base;
    rng_state = 32'hc848d8ca;
    areset = 1'b1;
    ctrl_start = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size_in_bytes = '0;
    tready = 1'b0;
    ready_roll = 1'b0;
    valid_roll = 1'b0;
    // Draw all requests first so the timeout can follow their sizes
    for (int i = 0; i < num_requests; i++) begin
      req_addr[i] = next_random();
      req_size[i] = int'(next_random() % 400) + 1;
      cycle_limit += ((req_size[i] + word_bytes - 1) / word_bytes) * 8 + 100;
    end
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    areset <= 1'b0;
    // Idle window for the reset-state checks
    repeat (4) @(negedge aclk);
    for (int i = 0; i < num_requests; i++) begin
      words  = (req_size[i] + word_bytes - 1) / word_bytes;
      bursts = (words + beats_per_burst - 1) / beats_per_burst;
      base   = req_addr[i] & ~(burst_bytes - 1);
      for (int k = 0; k < words; k++) begin
        exp_data.push_back((base + k * word_bytes) ^ data_pattern);
        exp_last.push_back((k % beats_per_burst == beats_per_burst - 1) || (k == words - 1));
      end
      // Full bursts and then a shorter one unless the count divides evenly
      for (int b = 0; b < bursts; b++) begin
        exp_araddr.push_back(base + b * burst_bytes);
        exp_arlen.push_back((b == bursts - 1) ? (words - 1) % beats_per_burst
                                              : beats_per_burst - 1);
      end
      exp_beats += words;
      req_idx = i;
      check_value("ctrl_done count before start", i, done_count);
      ctrl_start = 1'b1;
      ctrl_addr_offset = req_addr[i];
      ctrl_xfer_size_in_bytes = req_size[i];
      started = 1'b1;
      @(negedge aclk);
      ctrl_start = 1'b0;
      while (done_count <= i || exp_data.size() != 0) @(negedge aclk);
    end
    repeat (10) @(negedge aclk);
    check_value("ctrl_done count", num_requests, done_count);
    check_value("addresses left in model", 0, exp_araddr.size());
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  //////////////////////////////
  // Monitor at the rising edge
  //////////////////////////////

  always @(posedge aclk) begin
    if (areset === 1'b0) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("Checks %0d, errors %0d", checks, errors + 1);
        $display("ERRORS FOUND");
        $finish;
      end else begin
        check_value("m_axi_rready", 1, rready);
        // Quiet outputs between reset and the first start
        if (!started) begin
          check_value("m_axi_arvalid", 0, arvalid);
          check_value("m_axis_tvalid", 0, tvalid);
          check_value("ctrl_done", 0, ctrl_done);
        end
        if (arvalid && arready) begin
          if (exp_araddr.size() == 0) begin
            report_failure("address accepted with no burst expected");
          end else begin
            check_value("m_axi_araddr", exp_araddr.pop_front(), araddr);
            check_value("m_axi_arlen", exp_arlen.pop_front(), arlen);
          end
          outstanding++;
        end
        // A stalled word must stay put until taken
        if (held) begin
          check_value("m_axis_tvalid held", 1, tvalid);
          check_value("m_axis_tdata held", held_data, tdata);
          check_value("m_axis_tlast held", held_last, tlast);
        end
        if (tvalid && tready) begin
          if (exp_data.size() == 0) begin
            report_failure("stream word taken with no word expected");
          end else begin
            check_value("m_axis_tdata", exp_data.pop_front(), tdata);
            check_value("m_axis_tlast", exp_last.pop_front(), tlast);
          end
          if (tlast) outstanding--;
        end
        if (outstanding > `RD_MAX_OUTSTANDING) begin
          report_failure("too many bursts outstanding");
        end
        held = tvalid && !tready;
        held_data = tdata;
        held_last = tlast;
        if (rvalid) beats++;
        // Done once per request and only after all its beats
        if (ctrl_done) begin
          done_count++;
          check_value("ctrl_done count", req_idx + 1, done_count);
          check_value("R beats at ctrl_done", exp_beats, beats);
        end
      end
    end
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/rd_master_pkg.sv
source/rd_launch_if.sv
source/rd_request_setup.sv
source/rd_address_issuer.sv
source/rd_burst_tracker.sv
source/rd_data_buffer.sv
source/rd_master_top.sv
bench/axi_read_slave_model.sv
bench/rd_master_tb.sv

// ==== source/rd_address_issuer.sv ====
//////////////////////////////
// Issues full bursts then one final burst on AR
// Stalls while no outstanding slot is free
//////////////////////////////

`include "rd_master_settings.svh"

module rd_address_issuer
  import rd_master_pkg::*;
  (
  input  logic   aclk,
  input  logic   areset,
  rd_launch_if.sink launch,
  input  logic   m_axi_arready,
  input  logic   burst_drained,
  output logic   m_axi_arvalid,
  output addr_t  m_axi_araddr,
  output arlen_t m_axi_arlen
);

  // Address step per burst
  localparam addr_t burst_bytes = addr_t'(`RD_BURST_BEATS * (`RD_DATA_WIDTH / 8));
  // Length field of a full burst
  localparam arlen_t full_len = arlen_t'(`RD_BURST_BEATS - 1);
  // All slots free after reset
  localparam vacancy_t max_vacancy = vacancy_t'(`RD_MAX_OUTSTANDING);

  logic         ar_idle;
  logic         arxfer;
  logic         ar_final;
  logic         ar_done;
  logic         pending;
  logic         stall_ar;
  burst_count_t ar_to_go;
  vacancy_t     vacancy;

  //////////////////////////////
  // AR handshake
  //////////////////////////////

  assign arxfer   = m_axi_arvalid & m_axi_arready;
  assign ar_final = (ar_to_go == '0);
  assign ar_done  = ar_final & arxfer;
  // Launch counts as work so arvalid rises right after it
  assign pending  = launch.launch | ~ar_idle;
  assign stall_ar = (vacancy == '0);

  // Short length only on the last burst
  assign m_axi_arlen = ar_final ? arlen_t'(launch.final_len) : full_len;

  // Valid drops on acceptance, stays low one cycle before the next address
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
    end else if (pending & ~stall_ar & ~m_axi_arvalid) begin
      m_axi_arvalid <= 1'b1;
    end else if (m_axi_arready) begin
      m_axi_arvalid <= 1'b0;
    end
  end

  // Idle between the final address and the next launch
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (launch.launch) begin
      ar_idle <= 1'b0;
    end else if (ar_done) begin
      ar_idle <= 1'b1;
    end
  end

  // Bursts still to issue, zero marks the final one
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_to_go <= '0;
    end else if (launch.launch) begin
      ar_to_go <= launch.last_burst;
    end else if (arxfer & ~ar_final) begin
      ar_to_go <= ar_to_go - 1'b1;
    end
  end

  // Running address
  always_ff @(posedge aclk) begin
    if (launch.launch) begin
      m_axi_araddr <= launch.base_addr;
    end else if (arxfer) begin
      m_axi_araddr <= m_axi_araddr + burst_bytes;
    end
  end

  //////////////////////////////
  // Outstanding slots
  //////////////////////////////

  // Taken at address acceptance, returned when the burst leaves the buffer
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= max_vacancy;
    end else begin
      case ({burst_drained, arxfer})
        2'b10:   vacancy <= vacancy + 1'b1;
        2'b01:   vacancy <= vacancy - 1'b1;
        default: vacancy <= vacancy;
      endcase
    end
  end

endmodule

// ==== source/rd_burst_tracker.sv ====
//////////////////////////////
// Counts completed read bursts, pulses done
// Done may precede the data on the stream
//////////////////////////////

module rd_burst_tracker
  import rd_master_pkg::*;
  (
  input  logic aclk,
  input  logic areset,
  rd_launch_if.sink launch,
  input  logic m_axi_rvalid,
  input  logic m_axi_rlast,
  output logic ctrl_done
);

  logic         busy;
  logic         beat_last;
  logic         r_final;
  burst_count_t r_to_go;

  // rready is tied high, so every valid beat is accepted
  assign beat_last = m_axi_rvalid & m_axi_rlast;
  assign r_final   = (r_to_go == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      busy      <= 1'b0;
      r_to_go   <= '0;
      ctrl_done <= 1'b0;
    end else begin
      // Last beat of the last burst
      ctrl_done <= busy & beat_last & r_final;
      if (launch.launch) begin
        busy    <= 1'b1;
        r_to_go <= launch.last_burst;
      end else if (beat_last) begin
        if (r_final) begin
          busy <= 1'b0;
        end else begin
          r_to_go <= r_to_go - 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/rd_data_buffer.sv ====
//////////////////////////////
// First-word-fall-through buffer, R channel to stream
// No full flag, the issuer keeps it from overflowing
//////////////////////////////

`include "rd_master_settings.svh"

module rd_data_buffer
  import rd_master_pkg::*;
  (
  input  logic  aclk,
  input  logic  areset,
  input  logic  wr_valid,
  input  data_t wr_data,
  input  logic  wr_last,
  input  logic  m_axis_tready,
  output logic  m_axis_tvalid,
  output data_t m_axis_tdata,
  output logic  m_axis_tlast,
  output logic  burst_drained
);

  // Index bits below the wrap bit
  localparam int idx_width = $clog2(`RD_BUF_DEPTH);

  data_t    data_mem [`RD_BUF_DEPTH];
  logic     last_mem [`RD_BUF_DEPTH];
  buf_ptr_t wr_ptr;
  buf_ptr_t rd_ptr;
  logic     rd_take;

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Every valid beat is stored, rready is always high
  always_ff @(posedge aclk) begin
    if (wr_valid) begin
      data_mem[wr_ptr[idx_width-1:0]] <= wr_data;
      last_mem[wr_ptr[idx_width-1:0]] <= wr_last;
    end
  end

  //////////////////////////////
  // Pointers
  //////////////////////////////

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Stream side
  //////////////////////////////

  // Not empty means a word is waiting at the head
  assign m_axis_tvalid = (wr_ptr != rd_ptr);
  // Head word read straight from memory
  assign m_axis_tdata  = data_mem[rd_ptr[idx_width-1:0]];
  assign m_axis_tlast  = last_mem[rd_ptr[idx_width-1:0]];
  assign rd_take       = m_axis_tvalid & m_axis_tready;

  // Burst leaves the buffer, one slot frees up
  assign burst_drained = rd_take & m_axis_tlast;

endmodule

// ==== source/rd_launch_if.sv ====
//////////////////////////////
// Prepared request, setup to issuer and tracker
// Fields hold from launch until the next start
//////////////////////////////

interface rd_launch_if
  import rd_master_pkg::*;
  ();

  // One-cycle pulse, fields are valid with it
  logic launch;
  // Start address, aligned down to a burst boundary
  addr_t base_addr;
  // Number of bursts minus one
  burst_count_t last_burst;
  // Beats in the final burst minus one
  beat_idx_t final_len;

  // Request setup drives the bundle
  modport source (
    output launch, base_addr, last_burst, final_len
  );

  // Address issuer and burst tracker only read it
  modport sink (
    input launch, base_addr, last_burst, final_len
  );

endinterface

// ==== source/rd_master_pkg.sv ====
//////////////////////////////
// Vector types of the read engine
// All widths derive from the settings header
//////////////////////////////

`include "rd_master_settings.svh"

package rd_master_pkg;

  // Byte address on the AR channel
  typedef logic [`RD_ADDR_WIDTH-1:0] addr_t;

  // One bus word
  typedef logic [`RD_DATA_WIDTH-1:0] data_t;

  // Requested byte count
  typedef logic [`RD_SIZE_WIDTH-1:0] xfer_size_t;

  // Word count minus one, byte offset bits dropped
  typedef logic [`RD_SIZE_WIDTH-$clog2(`RD_DATA_WIDTH/8)-1:0] word_count_t;

  // Burst count minus one, the word count above the beat index
  typedef logic [$bits(word_count_t)-$clog2(`RD_BURST_BEATS)-1:0] burst_count_t;

  // AXI4 length field, fixed by the protocol
  typedef logic [7:0] arlen_t;

  // Length of the final burst minus one
  typedef logic [$clog2(`RD_BURST_BEATS)-1:0] beat_idx_t;

  // Free outstanding slots, zero up to the limit
  typedef logic [$clog2(`RD_MAX_OUTSTANDING+1)-1:0] vacancy_t;

  // Buffer pointer with one wrap bit above the index
  typedef logic [$clog2(`RD_BUF_DEPTH):0] buf_ptr_t;

endpackage

// ==== source/rd_master_settings.svh ====
//////////////////////////////
// Build-time settings for the read engine
// RD_BUF_DEPTH must be a power of two and hold every outstanding burst
//////////////////////////////

`ifndef RD_MASTER_SETTINGS_SVH
`define RD_MASTER_SETTINGS_SVH

// Byte address width on the AR channel
`define RD_ADDR_WIDTH 32

// Bus word width, read data and stream data
`define RD_DATA_WIDTH 32

// Width of the byte count at the control port
`define RD_SIZE_WIDTH 16

// Words in one full burst, far below the AXI limit of 256
`define RD_BURST_BEATS 16

// Bursts that may be in flight between AR and the stream
`define RD_MAX_OUTSTANDING 4

// Data buffer entries, burst beats times outstanding limit
`define RD_BUF_DEPTH 64

`endif

// ==== source/rd_master_top.sv ====
//////////////////////////////
// Burst read master, AXI4 read channels to a stream
// Start again only after done
//////////////////////////////

module rd_master_top
  import rd_master_pkg::*;
  (
  // Clock, reset and control
  input  logic       aclk,
  input  logic       areset,
  input  logic       ctrl_start,
  input  addr_t      ctrl_addr_offset,
  input  xfer_size_t ctrl_xfer_size_in_bytes,
  output logic       ctrl_done,
  // AR channel
  output logic       m_axi_arvalid,
  input  logic       m_axi_arready,
  output addr_t      m_axi_araddr,
  output arlen_t     m_axi_arlen,
  // R channel
  input  logic       m_axi_rvalid,
  output logic       m_axi_rready,
  input  data_t      m_axi_rdata,
  input  logic       m_axi_rlast,
  // Stream out
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  output data_t      m_axis_tdata,
  output logic       m_axis_tlast
);

  // Slot return from buffer to issuer
  logic burst_drained;

  // Prepared request bundle
  rd_launch_if launch_bus ();

  // The buffer holds all outstanding bursts, never back-pressure R
  assign m_axi_rready = 1'b1;

  rd_request_setup u_setup (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .launch                  (launch_bus.source)
  );

  rd_address_issuer u_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .launch        (launch_bus.sink),
    .m_axi_arready (m_axi_arready),
    .burst_drained (burst_drained),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  rd_burst_tracker u_tracker (
    .aclk         (aclk),
    .areset       (areset),
    .launch       (launch_bus.sink),
    .m_axi_rvalid (m_axi_rvalid),
    .m_axi_rlast  (m_axi_rlast),
    .ctrl_done    (ctrl_done)
  );

  rd_data_buffer u_buffer (
    .aclk          (aclk),
    .areset        (areset),
    .wr_valid      (m_axi_rvalid),
    .wr_data       (m_axi_rdata),
    .wr_last       (m_axi_rlast),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .burst_drained (burst_drained)
  );

endmodule

// ==== source/rd_request_setup.sv ====
//////////////////////////////
// Byte count rounds up to words, address aligns down to a burst
// A zero byte count is not supported
//////////////////////////////

`include "rd_master_settings.svh"

module rd_request_setup
  import rd_master_pkg::*;
  (
  input  logic       aclk,
  input  logic       areset,
  input  logic       ctrl_start,
  input  addr_t      ctrl_addr_offset,
  input  xfer_size_t ctrl_xfer_size_in_bytes,
  rd_launch_if.source launch
);

  // Byte offset bits within one bus word
  localparam int word_lsb = $clog2(`RD_DATA_WIDTH / 8);
  // Beat index bits within one burst
  localparam int beat_bits = $bits(beat_idx_t);
  // Byte offset within one full burst
  localparam addr_t burst_mask = addr_t'(`RD_BURST_BEATS * (`RD_DATA_WIDTH / 8) - 1);

  logic        start_d1;
  logic        has_tail;
  word_count_t words_floor;
  word_count_t word_count_m1;

  // Whole words in the request, partial word counted separately
  assign words_floor = ctrl_xfer_size_in_bytes[word_lsb +: $bits(word_count_t)];
  assign has_tail    = |ctrl_xfer_size_in_bytes[word_lsb-1:0];

  // Two-stage start, matches the two register stages below
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1      <= 1'b0;
      launch.launch <= 1'b0;
    end else begin
      start_d1      <= ctrl_start;
      launch.launch <= start_d1;
    end
  end

  // Stage 1, round up and align
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // A partial word adds one, so floor already is count minus one
      word_count_m1    <= has_tail ? words_floor : words_floor - 1'b1;
      launch.base_addr <= ctrl_addr_offset & ~burst_mask;
    end
  end

  // Stage 2, split into burst count and final burst length
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      launch.last_burst <= word_count_m1[beat_bits +: $bits(burst_count_t)];
      launch.final_len  <= word_count_m1[beat_bits-1:0];
    end
  end

endmodule
